//--- verilog/spi_bus_pkg.sv
// SPI bus bridge package
// Sizes and frame layout shared by the SPI master, request FIFO and RAM target

`default_nettype none

package spi_bus_pkg;

    // Bus widths
    localparam int unsigned ADDR_WIDTH     = 16;  // Sent as two SPI bytes
    localparam int unsigned DATA_WIDTH     = 8;

    // RAM holds 1024 bytes, upper address bits alias
    localparam int unsigned RAM_ADDR_WIDTH = 10;

    // Request FIFO entries, also the master's starting credit
    localparam int unsigned FIFO_DEPTH     = 4;
    localparam int unsigned CREDIT_WIDTH   = 3;   // Holds 0 to FIFO_DEPTH

    // Frame is cmd, addr hi, addr lo, data
    localparam int unsigned FRAME_BITS     = 32;
    localparam int unsigned CMD_WE_BIT     = 7;   // Write bit in command byte

endpackage

`default_nettype wire

//--- verilog/bus_req_if.sv
// Bus request interface
// Carries one request per valid beat, with a credit pulse back per freed slot

`timescale 1ns/1ps
`default_nettype none

interface bus_req_if;
    import spi_bus_pkg::*;

    logic                  valid;   // One beat per request
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic                  credit;  // Receiver freed one slot

    modport src (
        output valid,
        output we,
        output addr,
        output data,
        input  credit
    );

    modport dst (
        input  valid,
        input  we,
        input  addr,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

//--- verilog/spi_bus_master.sv
// SPI mode 0 slave, sampled by the system clock
// Turns complete 32 bit frames into bus requests under a credit counter,
// and returns the last read result in byte 1 of the next frame

`timescale 1ns/1ps
`default_nettype none

module spi_bus_master (
    input  logic                             clock_i,
    input  logic                             rst_n_i,

    // SPI pins
    input  logic                             spi_cs_ni,
    input  logic                             spi_sck_i,
    input  logic                             spi_sd_i,
    output logic                             spi_sd_o,
    output logic                             spi_stall_o,

    // Request out, read data back
    bus_req_if.src                           req,
    input  logic                             rd_valid_i,
    input  logic [spi_bus_pkg::DATA_WIDTH-1:0] rd_data_i
);
    import spi_bus_pkg::*;

    logic [2:0]                       pins_meta;   // {cs_n, sck, sd}
    logic [2:0]                       pins_sync;
    logic                             sck_q;
    logic                             cs_n;
    logic                             sck;
    logic                             sd;
    logic                             sck_rise;
    logic                             sck_fall;

    logic [$clog2(FRAME_BITS+1)-1:0]  bit_cnt;
    logic                             shift_en;
    logic                             last_bit;
    logic [FRAME_BITS-1:0]            frame_q;

    logic [CREDIT_WIDTH-1:0]          credit_cnt;
    logic                             rd_pending;
    logic [DATA_WIDTH-1:0]            rd_last;
    logic [DATA_WIDTH-1:0]            tx_shift;

    // Two flop synchronizers, plus one more SCK stage for edge detect
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pins_meta <= 3'b100;    // CS idles high
            pins_sync <= 3'b100;
            sck_q     <= 1'b0;
        end else begin
            pins_meta <= {spi_cs_ni, spi_sck_i, spi_sd_i};
            pins_sync <= pins_meta;
            sck_q     <= pins_sync[1];
        end
    end

    assign cs_n     = pins_sync[2];
    assign sck      = pins_sync[1];
    assign sd       = pins_sync[0];
    assign sck_rise = sck & ~sck_q;
    assign sck_fall = ~sck & sck_q;

    // Bits past the 32nd are ignored
    assign shift_en = sck_rise && !cs_n && (bit_cnt != $bits(bit_cnt)'(FRAME_BITS));
    assign last_bit = shift_en && (bit_cnt == $bits(bit_cnt)'(FRAME_BITS - 1));

    always_ff @(posedge clock_i) begin
        if (!rst_n_i || cs_n) begin
            bit_cnt <= '0;          // CS high drops a partial frame
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (shift_en) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], sd};   // MSB first
        end
    end

    // Request goes out the cycle after the 32nd rise
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= last_bit;
        end
    end

    assign req.we   = frame_q[FRAME_BITS - DATA_WIDTH + CMD_WE_BIT];
    assign req.addr = frame_q[DATA_WIDTH +: ADDR_WIDTH];
    assign req.data = frame_q[DATA_WIDTH-1:0];

    // Credits for the request FIFO
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CREDIT_WIDTH'(FIFO_DEPTH);
        end else begin
            case ({req.valid, req.credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;   // None, or spend and return
            endcase
        end
    end

    // Outstanding read, from request to rd_valid
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            rd_pending <= 1'b0;
        end else if (req.valid && !req.we) begin
            rd_pending <= 1'b1;
        end else if (rd_valid_i) begin
            rd_pending <= 1'b0;
        end
    end

    assign spi_stall_o = (credit_cnt == '0) || rd_pending;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            rd_last <= '0;
        end else if (rd_valid_i) begin
            rd_last <= rd_data_i;
        end
    end

    // Loaded while CS is high, shifted on falling SCK; zeros after byte 1
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            tx_shift <= '0;
        end else if (cs_n) begin
            tx_shift <= rd_last;
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_shift[DATA_WIDTH-1];

    // Credit count stays within the FIFO size
    a_credit_bound: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        credit_cnt <= CREDIT_WIDTH'(FIFO_DEPTH))
        else $error("credit count above FIFO depth");

    // Host must obey the stall, so no request without a credit
    a_valid_credit: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        req.valid |-> (credit_cnt != '0))
        else $error("request issued with zero credits");

endmodule

`default_nettype wire

//--- verilog/req_fifo.sv
// Request FIFO
// Circular buffer between SPI master and RAM, returns a credit upstream for
// every entry it forwards, and spends its own credits downstream

`timescale 1ns/1ps
`default_nettype none

module req_fifo (
    input  logic   clock_i,
    input  logic   rst_n_i,
    bus_req_if.dst up,
    bus_req_if.src dn
);
    import spi_bus_pkg::*;

    logic                          we_mem   [FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0]         addr_mem [FIFO_DEPTH];
    logic [DATA_WIDTH-1:0]         data_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [CREDIT_WIDTH-1:0]       count;
    logic [CREDIT_WIDTH-1:0]       dn_credits;   // RAM accepts one at a time
    logic                          pop;

    assign pop = (count != '0) && (dn_credits != '0);

    always_ff @(posedge clock_i) begin
        if (up.valid) begin
            we_mem[wr_ptr]   <= up.we;
            addr_mem[wr_ptr] <= up.addr;
            data_mem[wr_ptr] <= up.data;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (up.valid) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (pop)      rd_ptr <= rd_ptr + 1'b1;
            case ({up.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            dn_credits <= CREDIT_WIDTH'(1);
        end else begin
            case ({pop, dn.credit})
                2'b10:   dn_credits <= dn_credits - 1'b1;
                2'b01:   dn_credits <= dn_credits + 1'b1;
                default: dn_credits <= dn_credits;
            endcase
        end
    end

    // Head entry goes out as soon as a credit allows
    assign dn.valid  = pop;
    assign dn.we     = we_mem[rd_ptr];
    assign dn.addr   = addr_mem[rd_ptr];
    assign dn.data   = data_mem[rd_ptr];
    assign up.credit = pop;        // Slot freed this cycle

    a_no_overflow: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        up.valid |-> (count != CREDIT_WIDTH'(FIFO_DEPTH)))
        else $error("push into full request FIFO");

endmodule

`default_nettype wire

//--- verilog/ram_target.sv
// RAM target
// 1024 byte single port RAM, executes one request the cycle after it is
// accepted and returns a credit, plus read data for reads

`timescale 1ns/1ps
`default_nettype none

module ram_target (
    input  logic                               clock_i,
    input  logic                               rst_n_i,
    bus_req_if.dst                             req,
    output logic                               rd_valid_o,
    output logic [spi_bus_pkg::DATA_WIDTH-1:0] rd_data_o
);
    import spi_bus_pkg::*;

    logic [DATA_WIDTH-1:0]     mem [2**RAM_ADDR_WIDTH];

    logic                      busy;      // Executing the latched request
    logic                      we_q;
    logic [RAM_ADDR_WIDTH-1:0] addr_q;    // Upper bits alias
    logic [DATA_WIDTH-1:0]     data_q;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            rd_valid_o <= 1'b0;
            req.credit <= 1'b0;
        end else begin
            busy       <= req.valid;
            rd_valid_o <= busy && !we_q;
            req.credit <= busy;            // Completion
        end
    end

    always_ff @(posedge clock_i) begin
        if (req.valid) begin
            we_q   <= req.we;
            addr_q <= req.addr[RAM_ADDR_WIDTH-1:0];
            data_q <= req.data;
        end
    end

    // Write or registered read
    always_ff @(posedge clock_i) begin
        if (busy) begin
            if (we_q) begin
                mem[addr_q] <= data_q;
            end else begin
                rd_data_o <= mem[addr_q];
            end
        end
    end

    // FIFO holds its single credit until completion
    a_one_at_a_time: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        req.valid |-> !(busy || req.credit))
        else $error("request while RAM busy");

endmodule

`default_nettype wire

//--- verilog/spi_bridge_top.sv
// SPI to memory bridge top level
// SPI master feeds the request FIFO, which feeds the RAM target

`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top (
    input  logic clock_i,
    input  logic rst_n_i,

    // SPI bus
    input  logic spi_cs_ni,    // Chip select, active low
    input  logic spi_sck_i,
    input  logic spi_sd_i,     // Host to FPGA
    output logic spi_sd_o,     // FPGA to host
    output logic spi_stall_o
);
    import spi_bus_pkg::*;

    logic                  rd_valid;
    logic [DATA_WIDTH-1:0] rd_data;

    bus_req_if req_up ();
    bus_req_if req_dn ();

    spi_bus_master u_spi_bus_master (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .spi_cs_ni   (spi_cs_ni),
        .spi_sck_i   (spi_sck_i),
        .spi_sd_i    (spi_sd_i),
        .spi_sd_o    (spi_sd_o),
        .spi_stall_o (spi_stall_o),
        .req         (req_up.src),
        .rd_valid_i  (rd_valid),
        .rd_data_i   (rd_data)
    );

    req_fifo u_req_fifo (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .up      (req_up.dst),
        .dn      (req_dn.src)
    );

    ram_target u_ram_target (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .req        (req_dn.dst),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock and reset
// 100 ns clock, synchronous active low reset held for 4 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 4;

    initial begin
        clock_o = 1'b0;
        forever #(HALF_PERIOD_NS) clock_o = ~clock_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        rst_n_o <= 1'b1;    // Released on a rising edge
    end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
// Testbench checker
// Watches byte 1 of every SPI frame and the stall output, counts results

`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic        clock_i,
    input  logic        rst_n_i,
    input  logic        spi_cs_ni,
    input  logic        spi_sck_i,
    input  logic        spi_sdo_i,       // DUT serial output
    input  logic        spi_stall_i,
    input  logic [7:0]  exp_byte_i,      // Expected byte 1 of current frame
    input  logic        check_en_i,
    input  int          test_id_i,
    input  logic        test_end_i,
    input  logic        expect_stall_i,
    output logic [31:0] checks_o,
    output logic [31:0] errors_o,
    output logic [31:0] tests_o
);
    logic       sck_q;
    logic       cs_q;
    logic       first_cycle;
    logic       stall_seen;
    logic [7:0] rx_byte;
    int         bit_idx;
    int         check_cnt;
    int         error_cnt;
    int         test_cnt;
    int         test_checks;
    int         test_errors;

    assign checks_o = check_cnt;
    assign errors_o = error_cnt;
    assign tests_o  = test_cnt;

    function automatic string test_label(input int id);
        case (id)
            0:       return "reset_idle";
            1:       return "write_read";
            2:       return "random_frames";
            3:       return "write_burst";
            4:       return "aborted_frames";
            default: return "unknown";
        endcase
    endfunction

    task automatic record_error();
        error_cnt++;
        test_errors++;
    endtask

    always @(posedge clock_i) begin
        if (!rst_n_i) begin
            sck_q       = 1'b0;
            cs_q        = 1'b1;
            first_cycle = 1'b1;
            stall_seen  = 1'b0;
            rx_byte     = '0;
            bit_idx     = 0;
            check_cnt   = 0;
            error_cnt   = 0;
            test_cnt    = 0;
            test_checks = 0;
            test_errors = 0;
        end else begin
            if (first_cycle) begin            // Stall must be low out of reset
                check_cnt++;
                test_checks++;
                if (spi_stall_i) begin
                    $display("Error %s: spi_stall_o after reset expected 0, actual 1",
                             test_label(test_id_i));
                    record_error();
                end
            end
            first_cycle = 1'b0;
            if (spi_stall_i) begin
                stall_seen = 1'b1;
            end

            if (!spi_cs_ni && cs_q) begin     // Frame start
                bit_idx = 0;
                rx_byte = '0;
            end

            // Host samples SDO on rising SCK, byte 1 only
            if (!spi_cs_ni && spi_sck_i && !sck_q && bit_idx < 8) begin
                rx_byte = {rx_byte[6:0], spi_sdo_i};
                bit_idx++;
            end

            if (spi_cs_ni && !cs_q && check_en_i) begin
                check_cnt++;
                test_checks++;
                if (bit_idx != 8) begin
                    $display("%s: frame ended before byte 1 was complete",
                             test_label(test_id_i));
                    record_error();
                end else if (rx_byte != exp_byte_i) begin
                    $display("Error %s: byte 1 expected 0x%02h, actual 0x%02h",
                             test_label(test_id_i), exp_byte_i, rx_byte);
                    record_error();
                end
            end

            if (test_end_i) begin
                if (expect_stall_i && !stall_seen) begin
                    $display("%s: spi_stall_o never rose during the test",
                             test_label(test_id_i));
                    record_error();
                end
                $display("%s finished: %0d checks, %0d errors",
                         test_label(test_id_i), test_checks, test_errors);
                test_cnt++;
                test_checks = 0;
                test_errors = 0;
                stall_seen  = 1'b0;
            end

            sck_q = spi_sck_i;
            cs_q  = spi_cs_ni;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
// Testbench top for the SPI to memory bridge
// Acts as SPI host with random frames and keeps a reference model of the RAM

`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int HALF_SCK       = 4;      // Clocks per SCK half period
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_FRAMES     = 225;    // All tests together
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 32 * (2 * HALF_SCK) * 2 + RESET_CYCLES;

    logic        clock;
    logic        rst_n;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_sdi;       // Host to DUT
    logic        spi_sdo;       // DUT to host
    logic        spi_stall;

    logic [7:0]  exp_byte;
    logic        check_en;
    int          test_id;
    logic        test_end;
    logic        expect_stall;
    logic [31:0] checks;
    logic [31:0] errors;
    logic [31:0] tests;

    logic [31:0] lfsr_state;
    logic [7:0]  ref_mem [1024];
    logic        written_flag [1024];
    logic [9:0]  written [$];   // RAM addresses holding model data
    logic [7:0]  last_rd;       // Model of the DUT's last read result
    int          cycle_cnt;

    tb_clock_gen u_tb_clock_gen (
        .clock_o (clock),
        .rst_n_o (rst_n)
    );

    spi_bridge_top u_spi_bridge_top (
        .clock_i     (clock),
        .rst_n_i     (rst_n),
        .spi_cs_ni   (spi_cs_n),
        .spi_sck_i   (spi_sck),
        .spi_sd_i    (spi_sdi),
        .spi_sd_o    (spi_sdo),
        .spi_stall_o (spi_stall)
    );

    tb_checker u_tb_checker (
        .clock_i        (clock),
        .rst_n_i        (rst_n),
        .spi_cs_ni      (spi_cs_n),
        .spi_sck_i      (spi_sck),
        .spi_sdo_i      (spi_sdo),
        .spi_stall_i    (spi_stall),
        .exp_byte_i     (exp_byte),
        .check_en_i     (check_en),
        .test_id_i      (test_id),
        .test_end_i     (test_end),
        .expect_stall_i (expect_stall),
        .checks_o       (checks),
        .errors_o       (errors),
        .tests_o        (tests)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [9:0] pick_written();
        int idx;
        idx = int'(take_bits(10) % written.size());
        return written[idx];
    endfunction

    // Mode 0 host, waits for stall low before each frame
    task automatic send_frame(input logic we, input logic [15:0] addr, input logic [7:0] data,
                              input int nbits, input logic check, input int idle);
        logic [31:0] bits;
        bits = {we, 7'(take_bits(7)), addr, data};      // Reserved bits random
        repeat (idle) @(posedge clock);
        while (spi_stall) @(posedge clock);
        spi_cs_n <= 1'b0;
        exp_byte <= last_rd;
        check_en <= check;
        for (int i = 0; i < nbits; i++) begin
            spi_sdi <= bits[31 - i];
            repeat (HALF_SCK) @(posedge clock);
            spi_sck <= 1'b1;
            repeat (HALF_SCK) @(posedge clock);
            spi_sck <= 1'b0;
        end
        repeat (HALF_SCK) @(posedge clock);
        spi_cs_n <= 1'b1;
        repeat (HALF_SCK) @(posedge clock);
    endtask

    task automatic do_write(input logic [15:0] addr, input logic [7:0] data, input int idle);
        send_frame(1'b1, addr, data, 32, 1'b1, idle);
        ref_mem[addr[9:0]] = data;
        if (!written_flag[addr[9:0]]) begin
            written_flag[addr[9:0]] = 1'b1;
            written.push_back(addr[9:0]);
        end
    endtask

    // Upper address bits are random, they alias in the RAM
    task automatic do_read(input logic [9:0] ram_addr, input int idle);
        send_frame(1'b0, {6'(take_bits(6)), ram_addr}, 8'(take_bits(8)), 32, 1'b1, idle);
        last_rd = ref_mem[ram_addr];    // Seen in byte 1 of the next frame
    endtask

    task automatic start_test(input int id, input logic stall);
        @(posedge clock);
        test_id      <= id;
        expect_stall <= stall;
    endtask

    task automatic end_test();
        @(posedge clock);
        test_end <= 1'b1;
        @(posedge clock);
        test_end <= 1'b0;
    endtask

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] addr;
        logic [15:0] base;
        logic [9:0]  ram_addr;
        int          nbits;
        spi_cs_n     = 1'b1;
        spi_sck      = 1'b0;
        spi_sdi      = 1'b0;
        exp_byte     = '0;
        check_en     = 1'b0;
        test_id      = 0;
        test_end     = 1'b0;
        expect_stall = 1'b0;
        cycle_cnt    = 0;
        lfsr_state   = 32'h9cec;
        last_rd      = '0;
        for (int i = 0; i < 1024; i++) begin
            written_flag[i] = 1'b0;
        end

        @(posedge clock);
        while (!rst_n) @(posedge clock);

        // First frame returns the reset value
        start_test(0, 1'b0);
        do_write(16'(take_bits(16)), 8'(take_bits(8)), 0);
        end_test();

        start_test(1, 1'b0);
        addr = 16'(take_bits(16));
        do_write(addr, 8'(take_bits(8)), 0);
        do_read(addr[9:0], 0);
        do_write(16'(take_bits(16)), 8'(take_bits(8)), 0);
        end_test();

        start_test(2, 1'b0);
        for (int n = 0; n < 200; n++) begin
            if (written.size() == 0 || take_bits(1) == 32'd1) begin
                do_write(16'(take_bits(16)), 8'(take_bits(8)), int'(take_bits(3)));
            end else begin
                do_read(pick_written(), int'(take_bits(3)));
            end
        end
        do_write(16'(take_bits(16)), 8'(take_bits(8)), 0);
        end_test();

        // Each address written twice, later write must win
        start_test(3, 1'b1);
        base = 16'(take_bits(16));
        for (int n = 0; n < 8; n++) begin
            do_write(base + 16'(n % 4), 8'(take_bits(8)), 0);
        end
        for (int n = 0; n < 4; n++) begin
            do_read(10'(base + 16'(n)), 0);
        end
        do_write(16'(take_bits(16)), 8'(take_bits(8)), 0);
        end_test();

        start_test(4, 1'b0);
        for (int n = 0; n < 3; n++) begin
            ram_addr = pick_written();
            nbits    = 1 + int'(take_bits(5) % 31);
            send_frame(1'b1, {6'd0, ram_addr}, ~ref_mem[ram_addr], nbits, 1'b0, 0);
            do_read(ram_addr, 0);
        end
        do_write(16'(take_bits(16)), 8'(take_bits(8)), 0);
        end_test();

        repeat (2) @(posedge clock);
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/spi_bus_pkg.sv
verilog/bus_req_if.sv
verilog/spi_bus_master.sv
verilog/req_fifo.sv
verilog/ram_target.sv
verilog/spi_bridge_top.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the SPI bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f verilog.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation run OK" \
    || { echo "Simulation run FAILED"; exit 1; }
